//--- mem_subsys.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/map_if.sv
rtl/bank_if.sv
rtl/page_map.sv
rtl/mem_bank.sv
rtl/mem_bus.sv
rtl/mem_subsys.sv
tests/mem_subsys_tb.sv

//--- Makefile
# Verilator build and run of the memory subsystem testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mem_subsys_tb
FILELIST  = mem_subsys.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/mem_subsys_tb.sv
`timescale 1ns/10ps

module mem_subsys_tb
	import mem_pkg::*;
();

	localparam int NUM_RANDOM  = 320;                // random operations after the directed ones
	localparam int MAX_OPS     = 400;                // directed plus random, rounded up
	localparam int CYCLE_LIMIT = MAX_OPS * 8 + 200;  // eight cycles per op plus reset and margin

	logic        clk;
	logic        reset;
	logic        req;
	logic [1:0]  op;
	logic [3:0]  nb;
	logic [15:0] addr;
	logic [15:0] wdata;
	logic        ack;
	logic        err;
	logic [15:0] rdata;

	// reference map and physical memory
	bit          map_valid  [256];
	logic [3:0]  map_module [256];
	logic [3:0]  map_frame  [256];
	logic [15:0] mem_model  [int];                   // keyed by {module, frame, offset}
	logic [7:0]  used_pages [$];                     // pages that have been mapped

	int value_errors;
	int protocol_errors;
	int cycle_count;

	mem_subsys DUT (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.op    (op),
		.nb    (nb),
		.addr  (addr),
		.wdata (wdata),
		.ack   (ack),
		.err   (err),
		.rdata (rdata)
	);

	always #10 clk = ~clk;                           // 20 ns period

	// ========================================
	// run length guard
	// ========================================

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without finishing", cycle_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// fixed pages, out of range module or frame
	function automatic bit cmd_rejected(logic [15:0] cmd);
		return (cmd[15:8] < 8'd2) || (cmd[7:4] > 4'd1) || (cmd[3:0] > 4'd3);
	endfunction

	function automatic int phys_key(logic [7:0] page, logic [11:0] offset);
		return int'({map_module[page], map_frame[page], offset});
	endfunction

	// one four-phase transfer, entered and left just after a falling edge
	task automatic handshake(input logic [1:0] o, input logic [3:0] n, input logic [15:0] a,
			input logic [15:0] d, input int hold, output logic e, output logic [15:0] r);
		int waited;
		req   = 1'b1;
		op    = o;
		nb    = n;
		addr  = a;
		wdata = d;
		waited = 0;
		while (!ack && waited < 12) begin
			@(negedge clk);
			waited++;                                // first edge samples req
		end
		assert (ack) else begin
			protocol_errors++;
			$display("no ack within 12 cycles of req");
		end
		assert (waited == 4) else begin
			protocol_errors++;
			$display("[ERROR] ack latency: got 0x%0h exp 0x3", waited - 1);
		end
		e = err;
		r = rdata;
		repeat (hold) begin
			@(negedge clk);
			assert (ack && err === e && rdata === r) else begin
				protocol_errors++;
				$display("reply changed while req was still held");
			end
		end
		req = 1'b0;
		@(negedge clk);
		assert (!ack && !err) else begin
			protocol_errors++;
			$display("ack did not fall one cycle after req dropped");
		end
	endtask

	// drive one operation and compare it with the model
	task automatic check_op(input logic [1:0] o, input logic [3:0] n, input logic [15:0] a,
			input logic [15:0] d);
		logic [7:0]  page;
		bit          exp_err;
		bit          known;
		logic        got_err;
		logic [15:0] got_data;
		int          key;
		page = {n, a[15:12]};
		handshake(o, n, a, d, $urandom_range(0, 2), got_err, got_data);
		exp_err = (o == OP_CONFIG) ? cmd_rejected(d) : !map_valid[page];
		assert (got_err == exp_err) else begin
			value_errors++;
			$display("[ERROR] err op 0x%h page 0x%h: got 0x%h exp 0x%h", o, page, got_err, exp_err);
		end
		if (!exp_err && o == OP_CONFIG) begin
			map_valid[d[15:8]]  = 1'b1;
			map_module[d[15:8]] = d[7:4];
			map_frame[d[15:8]]  = d[3:0];
			known = 0;
			foreach (used_pages[i]) begin
				if (used_pages[i] == d[15:8]) known = 1;
			end
			if (!known) used_pages.push_back(d[15:8]);
		end else if (!exp_err) begin
			key = phys_key(page, a[11:0]);
			if (o == OP_WRITE) begin
				mem_model[key] = d;
			end else if (mem_model.exists(key)) begin   // never written words are not checked
				assert (got_data == mem_model[key]) else begin
					value_errors++;
					$display("[ERROR] rdata page 0x%h offset 0x%h: got 0x%h exp 0x%h",
						page, a[11:0], got_data, mem_model[key]);
				end
			end
		end
	endtask

	task automatic config_page(input logic [7:0] page, input logic [3:0] mod, input logic [3:0] fr);
		check_op(OP_CONFIG, 4'h0, 16'h0000, {page, mod, fr});
	endtask

	task automatic write_word(input logic [7:0] page, input logic [11:0] offset, input logic [15:0] d);
		check_op(OP_WRITE, page[7:4], {page[3:0], offset}, d);
	endtask

	task automatic read_word(input logic [7:0] page, input logic [11:0] offset);
		check_op(OP_READ, page[7:4], {page[3:0], offset}, 16'($urandom));
	endtask

	// ========================================
	// stimulus
	// ========================================

	initial begin
		logic [7:0]  page;
		logic [11:0] offset;
		void'($urandom(32'hf8ee_bc61));
		clk = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		op = OP_READ;
		nb = 4'h0;
		addr = 16'h0000;
		wdata = 16'h0000;
		value_errors = 0;
		protocol_errors = 0;
		cycle_count = 0;
		foreach (map_valid[i]) map_valid[i] = 1'b0;
		map_valid[0] = 1'b1;                         // page 0 -> module 0 frame 0
		map_module[0] = 4'd0;
		map_frame[0] = 4'd0;
		map_valid[1] = 1'b1;                         // page 1 -> module 0 frame 1
		map_module[1] = 4'd0;
		map_frame[1] = 4'd1;
		used_pages.push_back(8'h00);
		used_pages.push_back(8'h01);
		repeat (8) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		assert (!ack && !err) else begin
			value_errors++;
			$display("[ERROR] ack/err after reset: got 0x%h/0x%h exp 0x0/0x0", ack, err);
		end
		// unmapped pages and the fixed system pages
		read_word(8'h05, 12'h000);
		read_word(8'h30, 12'h123);
		write_word(8'h00, 12'h010, 16'h1234);
		write_word(8'h01, 12'h020, 16'h5678);
		read_word(8'h00, 12'h010);
		read_word(8'h01, 12'h020);
		// a valid command then data through the new page
		config_page(8'h23, 4'd1, 4'd2);
		write_word(8'h23, 12'h100, 16'hbeef);
		write_word(8'h23, 12'hfff, 16'h0f0f);
		read_word(8'h23, 12'h100);
		read_word(8'h23, 12'hfff);
		// commands that must be refused
		config_page(8'h00, 4'd1, 4'd3);
		config_page(8'h01, 4'd1, 4'd0);
		config_page(8'h25, 4'd2, 4'd0);
		config_page(8'h26, 4'd1, 4'd4);
		read_word(8'h00, 12'h010);
		read_word(8'h01, 12'h020);
		read_word(8'h25, 12'h000);
		read_word(8'h26, 12'h000);
		// separate modules, then an alias of one frame
		config_page(8'h30, 4'd0, 4'd3);
		config_page(8'h31, 4'd1, 4'd3);
		write_word(8'h30, 12'h040, 16'ha5a5);
		write_word(8'h31, 12'h040, 16'h5a5a);
		read_word(8'h30, 12'h040);
		read_word(8'h31, 12'h040);
		config_page(8'h32, 4'd0, 4'd3);
		write_word(8'h32, 12'h040, 16'hc3c3);
		read_word(8'h30, 12'h040);
		read_word(8'h31, 12'h040);

		// random mix, mostly on mapped pages
		for (int i = 0; i < NUM_RANDOM; i++) begin
			if ($urandom_range(0, 99) < 15) begin
				config_page(8'($urandom_range(0, 255)), 4'($urandom_range(0, 2)),
					4'($urandom_range(0, 4)));
			end else begin
				if ($urandom_range(0, 99) < 85) begin
					page = used_pages[$urandom_range(0, used_pages.size() - 1)];
				end else begin
					page = 8'($urandom_range(0, 255));
				end
				offset = 12'($urandom_range(0, 31)) | ($urandom_range(0, 1) ? 12'hf80 : 12'h000);
				if ($urandom_range(0, 1)) begin
					write_word(page, offset, 16'($urandom));
				end else begin
					read_word(page, offset);
				end
			end
		end

		$display("errors: value %0d, protocol %0d", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- rtl/mem_subsys.sv
`timescale 1ns/10ps

module mem_subsys (
	input  logic        clk,
	input  logic        reset,
	input  logic        req,      // four-phase request
	input  logic [1:0]  op,       // read, write or configure
	input  logic [3:0]  nb,       // block number
	input  logic [15:0] addr,     // top 4 bits pick the page
	input  logic [15:0] wdata,    // data word or map command
	output logic        ack,
	output logic        err,
	output logic [15:0] rdata
);

	// ========================================
	// internal links
	// ========================================

	map_if  map_link ();          // controller <-> page map
	bank_if bank0_link ();        // controller <-> module 0
	bank_if bank1_link ();        // controller <-> module 1

	// ========================================
	// controller, map and memory modules
	// ========================================

	mem_bus u_bus (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.op    (op),
		.nb    (nb),
		.addr  (addr),
		.wdata (wdata),
		.ack   (ack),
		.err   (err),
		.rdata (rdata),
		.map   (map_link),
		.bank0 (bank0_link),
		.bank1 (bank1_link)
	);

	page_map u_map (
		.clk   (clk),
		.reset (reset),
		.map   (map_link)
	);

	mem_bank u_bank0 (
		.clk (clk),
		.bus (bank0_link)
	);

	mem_bank u_bank1 (
		.clk (clk),
		.bus (bank1_link)
	);

endmodule

//--- rtl/mem_bus.sv
`timescale 1ns/10ps
`include "mem_config.svh"

module mem_bus
	import mem_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        req,
	input  logic [1:0]  op,
	input  logic [3:0]  nb,
	input  logic [15:0] addr,
	input  logic [15:0] wdata,
	output logic        ack,
	output logic        err,
	output logic [15:0] rdata,
	map_if.ctrl         map,
	bank_if.ctrl        bank0,
	bank_if.ctrl        bank1
);

	localparam logic [2:0] S_IDLE   = 3'd0;   // waiting for req
	localparam logic [2:0] S_LOOKUP = 3'd1;   // page index goes to the map
	localparam logic [2:0] S_ACCESS = 3'd2;   // map write or module access
	localparam logic [2:0] S_REPLY  = 3'd3;   // module data comes back
	localparam logic [2:0] S_HOLD   = 3'd4;   // ack high until req drops

	logic [2:0]  state;
	logic        ack_q;
	logic        status_q;
	logic [1:0]  op_q;
	logic [3:0]  nb_q;
	logic [15:0] addr_q;
	mem_word_u   wdata_q;
	logic [15:0] rdata_q;

	logic [`MODULE_ADDR_WIDTH-1:0] bank_sel;   // module named by the map entry
	logic [`MODULE_ADDR_WIDTH-1:0] sel_q;      // same, kept for the reply cycle
	logic        is_mem_op;
	logic        mem_go;
	logic [15:0] bank_rdata;

	assign bank_sel  = map.entry_module[`MODULE_ADDR_WIDTH-1:0];
	assign is_mem_op = (op_q == OP_READ) || (op_q == OP_WRITE);
	assign mem_go    = (state == S_ACCESS) && is_mem_op && map.entry_valid;

	// ========================================
	// map and module steering
	// ========================================

	assign map.lookup_page = {nb_q, addr_q[15:`OFFSET_WIDTH]};
	assign map.cfg_wr      = (state == S_ACCESS) && (op_q == OP_CONFIG);
	assign map.cfg_word    = wdata_q;

	assign bank0.en     = mem_go && (bank_sel == 0);
	assign bank0.we     = op_q == OP_WRITE;
	assign bank0.frame  = map.entry_frame;
	assign bank0.offset = addr_q[`OFFSET_WIDTH-1:0];
	assign bank0.wdata  = wdata_q.data;

	assign bank1.en     = mem_go && (bank_sel == 1);
	assign bank1.we     = op_q == OP_WRITE;
	assign bank1.frame  = map.entry_frame;
	assign bank1.offset = addr_q[`OFFSET_WIDTH-1:0];
	assign bank1.wdata  = wdata_q.data;

	assign bank_rdata = (sel_q == 0) ? bank0.rdata : bank1.rdata;   // merge the two replies

	// ========================================
	// handshake sequencer
	// ========================================

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= S_IDLE;
			ack_q    <= 1'b0;
			status_q <= STATUS_OK;
		end else begin
			case (state)
				S_IDLE: begin
					if (req) begin
						state <= S_LOOKUP;
					end
				end
				S_LOOKUP: begin
					state <= S_ACCESS;               // entry registers at this edge
				end
				S_ACCESS: begin
					state <= S_REPLY;
					if (op_q == OP_CONFIG) begin
						status_q <= map.cfg_reject ? STATUS_ERR : STATUS_OK;
					end else if (is_mem_op) begin
						status_q <= map.entry_valid ? STATUS_OK : STATUS_ERR;   // unmapped page
					end else begin
						status_q <= STATUS_ERR;      // reserved op code
					end
				end
				S_REPLY: begin
					state <= S_HOLD;
					ack_q <= 1'b1;
				end
				S_HOLD: begin
					if (!req) begin
						state <= S_IDLE;
						ack_q <= 1'b0;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// request fields and reply word
	always_ff @(posedge clk) begin
		if ((state == S_IDLE) && req) begin
			op_q    <= op;
			nb_q    <= nb;
			addr_q  <= addr;
			wdata_q <= wdata;
		end
		if (state == S_ACCESS) begin
			sel_q <= bank_sel;
		end
		if (state == S_REPLY) begin
			rdata_q <= ((op_q == OP_READ) && (status_q == STATUS_OK)) ? bank_rdata : 16'd0;
		end
	end

	assign ack   = ack_q;
	assign err   = ack_q && (status_q == STATUS_ERR);
	assign rdata = rdata_q;

	// ack is only raised while the requester still holds req
	a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
		$rose(ack_q) |-> $past(req));

	// reply stays put while the requester keeps req high
	a_reply_holds: assert property (@(posedge clk) disable iff (reset)
		(ack_q && req) |=> $stable({ack_q, status_q, rdata_q}));

endmodule

//--- rtl/mem_bank.sv
`timescale 1ns/10ps
`include "mem_config.svh"

module mem_bank (
	input logic clk,
	bank_if.ram bus
);

	localparam int ADDR_WIDTH = `FRAME_ADDR_WIDTH + `OFFSET_WIDTH;
	localparam int DEPTH      = `FRAMES_PER_MODULE << `OFFSET_WIDTH;   // all frames back to back

	logic [15:0]           ram [DEPTH];
	logic [ADDR_WIDTH-1:0] word_addr;

	// frame selects the 4K slice, offset the word inside it
	assign word_addr = {bus.frame[`FRAME_ADDR_WIDTH-1:0], bus.offset};

	// ========================================
	// synchronous write, registered read
	// ========================================

	always_ff @(posedge clk) begin
		if (bus.en) begin
			if (bus.we) begin
				ram[word_addr] <= bus.wdata;     // lands at this edge
			end
			bus.rdata <= ram[word_addr];         // old contents on a write, ignored upstream
		end
	end

	// the page map only accepts frames this module really holds
	a_frame_installed: assert property (@(posedge clk)
		bus.en |-> (bus.frame < 4'(`FRAMES_PER_MODULE)));

endmodule

//--- rtl/page_map.sv
`timescale 1ns/10ps
`include "mem_config.svh"

module page_map (
	input logic clk,
	input logic reset,
	map_if.tbl  map
);

	// field bits that may be set for an installed module or frame
	localparam logic [3:0] MODULE_MASK = 4'(`NUM_MODULES - 1);
	localparam logic [3:0] FRAME_MASK  = 4'(`FRAMES_PER_MODULE - 1);

	logic [255:0] valid_q;            // one bit per page
	logic [3:0]   module_q [256];
	logic [3:0]   frame_q  [256];

	logic [7:0] cfg_index;            // page named by the command
	logic       fixed_page;
	logic       module_bad;
	logic       frame_bad;
	logic       cfg_accept;

	// ========================================
	// command decode and validation
	// ========================================

	assign cfg_index  = {map.cfg_word.cmd.cfg_nb, map.cfg_word.cmd.cfg_page};
	assign fixed_page = cfg_index < 8'd2;                  // system pages 0 and 1 of block 0
	assign module_bad = |(map.cfg_word.cmd.cfg_module & ~MODULE_MASK);   // module not installed
	assign frame_bad  = |(map.cfg_word.cmd.cfg_frame & ~FRAME_MASK);     // frame past the end

	assign map.cfg_reject = fixed_page || module_bad || frame_bad;
	assign cfg_accept     = map.cfg_wr && !map.cfg_reject;

	// ========================================
	// table update
	// ========================================

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 256'd3;                   // only the two system pages are mapped
		end else if (cfg_accept) begin
			valid_q[cfg_index] <= 1'b1;          // entries never go invalid again
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			module_q[0] <= 4'd0;   // page 0 -> module 0 frame 0
			frame_q[0]  <= 4'd0;
			module_q[1] <= 4'd0;   // page 1 -> module 0 frame 1
			frame_q[1]  <= 4'd1;
		end else if (cfg_accept) begin
			module_q[cfg_index] <= map.cfg_word.cmd.cfg_module;
			frame_q[cfg_index]  <= map.cfg_word.cmd.cfg_frame;
		end
	end

	// ========================================
	// registered lookup
	// ========================================

	always_ff @(posedge clk) begin
		if (reset) begin
			map.entry_valid <= 1'b0;
		end else begin
			map.entry_valid <= valid_q[map.lookup_page];   // sees the table before this edge's write
		end
	end

	always_ff @(posedge clk) begin
		map.entry_module <= module_q[map.lookup_page];
		map.entry_frame  <= frame_q[map.lookup_page];
	end

	// a valid lookup only ever names memory that is installed
	a_entry_installed: assert property (@(posedge clk) disable iff (reset)
		map.entry_valid |-> (((map.entry_module & ~MODULE_MASK) == 4'd0)
			&& ((map.entry_frame & ~FRAME_MASK) == 4'd0)));

endmodule

//--- rtl/bank_if.sv
`timescale 1ns/10ps
`include "mem_config.svh"

interface bank_if;

	logic                     en;       // only the selected module sees this high
	logic                     we;       // store instead of fetch
	logic [3:0]               frame;    // frame field as it comes from the map
	logic [`OFFSET_WIDTH-1:0] offset;   // word within the frame
	logic [15:0]              wdata;
	logic [15:0]              rdata;    // valid the cycle after en

	modport ctrl (
		output en, we, frame, offset, wdata,
		input  rdata
	);

	modport ram (
		input  en, we, frame, offset, wdata,
		output rdata
	);

endinterface

//--- rtl/map_if.sv
`timescale 1ns/10ps

interface map_if
	import mem_pkg::*;
();

	logic [7:0] lookup_page;    // {nb, addr[15:12]} of the latched request
	logic       cfg_wr;         // one cycle strobe, write the entry named in cfg_word
	mem_word_u  cfg_word;       // map command as carried on the data lines

	logic       entry_valid;    // registered result of the lookup
	logic [3:0] entry_module;
	logic [3:0] entry_frame;
	logic       cfg_reject;     // combinational verdict on cfg_word

	modport ctrl (
		output lookup_page, cfg_wr, cfg_word,
		input  entry_valid, entry_module, entry_frame, cfg_reject
	);

	modport tbl (
		input  lookup_page, cfg_wr, cfg_word,
		output entry_valid, entry_module, entry_frame, cfg_reject
	);

endinterface

//--- rtl/mem_pkg.sv
package mem_pkg;

	// ========================================
	// bus operation codes
	// ========================================

	localparam logic [1:0] OP_READ   = 2'd0;   // fetch one word
	localparam logic [1:0] OP_WRITE  = 2'd1;   // store one word
	localparam logic [1:0] OP_CONFIG = 2'd2;   // data word carries a map command
	// code 3 is reserved and answered with err

	// ========================================
	// reply status
	// ========================================

	localparam logic STATUS_OK  = 1'b0;   // data or command accepted
	localparam logic STATUS_ERR = 1'b1;   // unmapped page, rejected command, bad op

	// one bus data word, seen either as plain data or as a map command
	typedef union packed {
		logic [15:0] data;             // raw word for read and write
		struct packed {
			logic [3:0] cfg_nb;        // block number of the page to map
			logic [3:0] cfg_page;      // page within that block
			logic [3:0] cfg_module;    // target memory module
			logic [3:0] cfg_frame;     // target frame inside the module
		} cmd;
	} mem_word_u;

endpackage

//--- rtl/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// ========================================
// installed memory geometry
// ========================================

// module number bits the bus actually decodes
`define MODULE_ADDR_WIDTH 1

// frame number bits inside one module
`define FRAME_ADDR_WIDTH 2

// word offset inside a 4K frame
`define OFFSET_WIDTH 12

// ========================================
// derived counts
// ========================================

`define NUM_MODULES (1 << `MODULE_ADDR_WIDTH)        // modules behind the controller
`define FRAMES_PER_MODULE (1 << `FRAME_ADDR_WIDTH)   // frames held by each module

`endif
